// File: src/decodePkg.sv
package decodePkg;

	//////////////////////////////
	// Widths and plain vectors
	//////////////////////////////

	localparam int instrWidth = 18;
	localparam int dataWidth = 16;
	localparam int regIdxWidth = 4;
	localparam int jumpCodeWidth = 5;

	typedef logic [instrWidth-1:0] instr_t;
	typedef logic [regIdxWidth-1:0] regIdx_t;
	typedef logic [dataWidth-1:0] word_t;
	typedef logic [3:0] aluOp_t;

	// Registers behind the second write port
	localparam regIdx_t bankTwoLow = 4'd12;
	localparam regIdx_t bankTwoHigh = 4'd13;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	typedef enum logic [2:0] {
		regPlain,
		memMove,
		regImm,
		jumpGroup,
		unsupported
	} instClass_e;

	// MUL and FMUL are reserved
	typedef enum logic [3:0] {
		ADD = 4'd2,
		SUB = 4'd3,
		AND = 4'd4,
		OR = 4'd5,
		XOR = 4'd6,
		NOT = 4'd7,
		LSH = 4'd8,
		RSH = 4'd9,
		ARSH = 4'd10,
		CMP = 4'd11,
		CMPR = 4'd12,
		MOVR = 4'd13,
		MUL = 4'd14,
		FMUL = 4'd15
	} aluOpcode_e;

	typedef enum logic [3:0] {
		MOVMR = 4'd0,
		MOVRM = 4'd1
	} memOpcode_e;

	// Sits in instruction bits 17:13
	typedef enum logic [jumpCodeWidth-1:0] {
		J = 5'b01000,
		JE = 5'b01001,
		JNE = 5'b01010,
		JL = 5'b01011,
		JLE = 5'b01100,
		JB = 5'b01101,
		JBE = 5'b01110
	} jumpCode_e;

	typedef enum logic [1:0] {
		wbNone,
		wbAlu,
		wbMove,
		wbMem
	} wbSel_e;

	//////////////////////////////
	// Pipeline payloads
	//////////////////////////////

	typedef struct packed {
		logic low;
		logic negative;
		logic zero;
	} flags_t;

	typedef struct packed {
		instr_t instr;
		flags_t flags;
	} decodeIn_t;

	typedef struct packed {
		instr_t instr;
		flags_t flags;
		instClass_e instClass;
	} classified_t;

	typedef struct packed {
		aluOp_t aluOp;
		regIdx_t destSel;
		regIdx_t srcSel;
		logic useImm;
		word_t immediate;
		wbSel_e wbSel;
		logic writeEn1;
		logic writeEn2;
		logic flagWrite;
		logic memRead;
		logic memWrite;
		logic memAddrFromReg;
		logic jump;
		word_t target;
		logic pcAdvance;
	} ctrlWord_t;

	typedef struct packed {
		ctrlWord_t ctrl;
		flags_t flags;
		logic isJump;
		jumpCode_e jumpCode;
	} stage2Out_t;

endpackage

// File: src/instrClassify.sv
`timescale 1ns/1ps

module instrClassify (
	input logic clk,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input decodePkg::decodeIn_t inData,
	output logic s1Valid,
	input logic s1Ready,
	output decodePkg::classified_t s1Data
);

	decodePkg::instClass_e nextClass;

	// Class comes from the top two bits, then the upper nibble
	always_comb begin
		case (inData.instr[17:16])
			2'b00: begin
				if (inData.instr[15:12] == 4'b0000) begin
					nextClass = decodePkg::regPlain;
				end else if (inData.instr[15:12] == 4'b0001) begin
					nextClass = decodePkg::memMove;
				end else begin
					nextClass = decodePkg::regImm;
				end
			end
			2'b01, 2'b10: begin
				nextClass = decodePkg::jumpGroup;
			end
			default: begin
				nextClass = decodePkg::unsupported;
			end
		endcase
	end

	assign inReady = !s1Valid || s1Ready;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
		end else if (inReady) begin
			s1Valid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			s1Data.instr <= inData.instr;
			s1Data.flags <= inData.flags;
			s1Data.instClass <= nextClass;
		end
	end

	// Held item may not change until stage 2 takes it
	stage1Hold: assert property (@(posedge clk) disable iff (!rstN)
		s1Valid && !s1Ready |=> s1Valid && $stable(s1Data));

endmodule

// File: src/fieldDecode.sv
`timescale 1ns/1ps

module fieldDecode (
	input logic clk,
	input logic rstN,
	input logic s1Valid,
	output logic s1Ready,
	input decodePkg::classified_t s1Data,
	output logic s2Valid,
	input logic s2Ready,
	output decodePkg::stage2Out_t s2Data
);

	decodePkg::stage2Out_t nextData;
	decodePkg::instr_t instr;
	decodePkg::aluOp_t aluField;
	decodePkg::regIdx_t srcField;
	logic isImm;
	logic bankTwo;
	logic regWrite;

	assign instr = s1Data.instr;
	assign isImm = (s1Data.instClass == decodePkg::regImm);

	// Immediate form moves the opcode up and reuses the register as source
	assign aluField = isImm ? instr[15:12] : instr[7:4];
	assign srcField = isImm ? instr[11:8] : instr[3:0];

	assign bankTwo = (instr[11:8] == decodePkg::bankTwoLow) ||
		(instr[11:8] == decodePkg::bankTwoHigh);

	always_comb begin
		nextData = '0;
		regWrite = 1'b0;
		case (s1Data.instClass)
			decodePkg::regPlain, decodePkg::regImm: begin
				nextData.ctrl.aluOp = aluField;
				nextData.ctrl.destSel = instr[11:8];
				nextData.ctrl.srcSel = srcField;
				if (isImm) begin
					nextData.ctrl.useImm = 1'b1;
					nextData.ctrl.immediate = decodePkg::word_t'(instr[7:0]);
				end
				case (aluField)
					decodePkg::ADD, decodePkg::SUB, decodePkg::AND,
					decodePkg::OR, decodePkg::XOR, decodePkg::NOT,
					decodePkg::LSH, decodePkg::RSH, decodePkg::ARSH: begin
						nextData.ctrl.wbSel = decodePkg::wbAlu;
						nextData.ctrl.flagWrite = 1'b1;
						regWrite = 1'b1;
					end
					decodePkg::CMP, decodePkg::CMPR: begin
						nextData.ctrl.flagWrite = 1'b1;
					end
					decodePkg::MOVR: begin
						nextData.ctrl.wbSel = decodePkg::wbMove;
						regWrite = 1'b1;
					end
					// MUL, FMUL and the unused codes
					default: begin
						nextData.ctrl = '0;
					end
				endcase
			end
			decodePkg::memMove: begin
				nextData.ctrl.destSel = instr[11:8];
				nextData.ctrl.srcSel = instr[3:0];
				case (instr[7:4])
					decodePkg::MOVMR: begin
						nextData.ctrl.memRead = 1'b1;
						nextData.ctrl.wbSel = decodePkg::wbMem;
						nextData.ctrl.memAddrFromReg = 1'b1;
						regWrite = 1'b1;
					end
					decodePkg::MOVRM: begin
						nextData.ctrl.memWrite = 1'b1;
						nextData.ctrl.memAddrFromReg = 1'b1;
					end
					default: begin
						nextData.ctrl = '0;
					end
				endcase
			end
			decodePkg::jumpGroup: begin
				nextData.isJump = 1'b1;
				nextData.jumpCode = decodePkg::jumpCode_e'(instr[17:13]);
				nextData.ctrl.target = decodePkg::word_t'(instr[12:0]);
			end
			default: begin
				nextData.ctrl = '0;
			end
		endcase

		// Port choice by destination bank
		nextData.ctrl.writeEn1 = regWrite && !bankTwo;
		nextData.ctrl.writeEn2 = regWrite && bankTwo;
		nextData.flags = s1Data.flags;
	end

	assign s1Ready = !s2Valid || s2Ready;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			s2Valid <= 1'b0;
		end else if (s1Ready) begin
			s2Valid <= s1Valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1Valid && s1Ready) begin
			s2Data <= nextData;
		end
	end

	stage2Hold: assert property (@(posedge clk) disable iff (!rstN)
		s2Valid && !s2Ready |=> s2Valid && $stable(s2Data));

	oneWritePort: assert property (@(posedge clk) disable iff (!rstN)
		s2Valid |-> !(s2Data.ctrl.writeEn1 && s2Data.ctrl.writeEn2));

	memOneWay: assert property (@(posedge clk) disable iff (!rstN)
		s2Valid |-> !(s2Data.ctrl.memRead && s2Data.ctrl.memWrite));

endmodule

// File: src/branchResolve.sv
`timescale 1ns/1ps

module branchResolve (
	input logic clk,
	input logic rstN,
	input logic s2Valid,
	output logic s2Ready,
	input decodePkg::stage2Out_t s2Data,
	output logic outValid,
	input logic outReady,
	output decodePkg::ctrlWord_t outData
);

	decodePkg::ctrlWord_t resolved;
	logic taken;
	logic knownCode;

	// Condition table against the flags carried with the jump
	always_comb begin
		taken = 1'b0;
		knownCode = 1'b1;
		if (s2Data.isJump) begin
			case (s2Data.jumpCode)
				decodePkg::J: taken = 1'b1;
				decodePkg::JE: taken = s2Data.flags.zero;
				decodePkg::JNE: taken = !s2Data.flags.zero;
				decodePkg::JL: taken = s2Data.flags.negative;
				decodePkg::JLE: taken = s2Data.flags.negative || s2Data.flags.zero;
				decodePkg::JB: taken = s2Data.flags.low;
				decodePkg::JBE: taken = s2Data.flags.low || s2Data.flags.zero;
				default: knownCode = 1'b0;
			endcase
		end
	end

	always_comb begin
		resolved = s2Data.ctrl;
		resolved.jump = taken;
		resolved.pcAdvance = !taken;
		// Unknown jump code becomes a plain no-op
		if (!knownCode) begin
			resolved = '0;
			resolved.pcAdvance = 1'b1;
		end
	end

	assign s2Ready = !outValid || outReady;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (s2Ready) begin
			outValid <= s2Valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s2Valid && s2Ready) begin
			outData <= resolved;
		end
	end

	outHold: assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outData));

	jumpOrAdvance: assert property (@(posedge clk) disable iff (!rstN)
		outValid |-> !(outData.jump && outData.pcAdvance));

endmodule

// File: src/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
	input logic clk,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input decodePkg::decodeIn_t inData,
	output logic outValid,
	input logic outReady,
	output decodePkg::ctrlWord_t outData
);

	logic s1Valid;
	logic s1Ready;
	decodePkg::classified_t s1Data;

	logic s2Valid;
	logic s2Ready;
	decodePkg::stage2Out_t s2Data;

	instrClassify classify_inst (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.s1Valid(s1Valid),
		.s1Ready(s1Ready),
		.s1Data(s1Data)
	);

	fieldDecode decode_inst (
		.clk(clk),
		.rstN(rstN),
		.s1Valid(s1Valid),
		.s1Ready(s1Ready),
		.s1Data(s1Data),
		.s2Valid(s2Valid),
		.s2Ready(s2Ready),
		.s2Data(s2Data)
	);

	branchResolve resolve_inst (
		.clk(clk),
		.rstN(rstN),
		.s2Valid(s2Valid),
		.s2Ready(s2Ready),
		.s2Data(s2Data),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

endmodule

// File: verification/decoderModel.svh
// Expected control word for one instruction and its flags
function automatic decodePkg::ctrlWord_t expectCtrl(
	input decodePkg::instr_t instr,
	input decodePkg::flags_t flags
);
	decodePkg::ctrlWord_t c;
	logic [3:0] op;
	logic immForm;
	logic writes;
	logic taken;
	logic known;

	c = '0;
	c.pcAdvance = 1'b1;
	writes = 1'b0;
	taken = 1'b0;
	known = 1'b1;
	immForm = (instr[15:12] != 4'h0);
	op = immForm ? instr[15:12] : instr[7:4];

	if (instr[17:16] == 2'b00 && instr[15:12] == 4'h1) begin
		// Only MOVMR and MOVRM exist in this group
		if (instr[7:4] == decodePkg::MOVMR || instr[7:4] == decodePkg::MOVRM) begin
			c.destSel = instr[11:8];
			c.srcSel = instr[3:0];
			c.memAddrFromReg = 1'b1;
			c.memRead = (instr[7:4] == decodePkg::MOVMR);
			c.memWrite = !c.memRead;
			c.wbSel = c.memRead ? decodePkg::wbMem : decodePkg::wbNone;
			writes = c.memRead;
		end
	end else if (instr[17:16] == 2'b00) begin
		if (op >= decodePkg::ADD && op <= decodePkg::MOVR) begin
			c.aluOp = op;
			c.destSel = instr[11:8];
			c.srcSel = immForm ? instr[11:8] : instr[3:0];
			c.useImm = immForm;
			c.immediate = immForm ? {8'h00, instr[7:0]} : 16'h0000;
			if (op == decodePkg::MOVR) begin
				c.wbSel = decodePkg::wbMove;
				writes = 1'b1;
			end else if (op >= decodePkg::CMP) begin
				c.flagWrite = 1'b1;
			end else begin
				c.wbSel = decodePkg::wbAlu;
				c.flagWrite = 1'b1;
				writes = 1'b1;
			end
		end
	end else if (instr[17:16] != 2'b11) begin
		case (instr[17:13])
			decodePkg::J: taken = 1'b1;
			decodePkg::JE: taken = flags.zero;
			decodePkg::JNE: taken = !flags.zero;
			decodePkg::JL: taken = flags.negative;
			decodePkg::JLE: taken = flags.negative || flags.zero;
			decodePkg::JB: taken = flags.low;
			decodePkg::JBE: taken = flags.low || flags.zero;
			default: known = 1'b0;
		endcase
		if (known) begin
			c.target = {3'b000, instr[12:0]};
			c.jump = taken;
			c.pcAdvance = !taken;
		end
	end

	// Registers 12 and 13 sit behind the second port
	if (instr[11:8] == decodePkg::bankTwoLow || instr[11:8] == decodePkg::bankTwoHigh) begin
		c.writeEn2 = writes;
	end else begin
		c.writeEn1 = writes;
	end
	return c;
endfunction

// File: verification/decoderTb.sv
`timescale 1ns/1ps

module decoderTb;

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	decodePkg::decodeIn_t inData;
	logic outValid;
	logic outReady;
	decodePkg::ctrlWord_t outData;

	decodePkg::decodeIn_t stimQ[$];
	decodePkg::ctrlWord_t scoreQ[$];
	decodePkg::ctrlWord_t headExpect;
	logic headValid;
	logic afterReset = 1'b0;
	int itemTotal = 0;

	`include "decoderModel.svh"

	controlDecoder controlDecoder_inst (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	function automatic string firstBadField(
		input decodePkg::ctrlWord_t got,
		input decodePkg::ctrlWord_t exp
	);
		if (got.aluOp != exp.aluOp) return "aluOp";
		if (got.destSel != exp.destSel) return "destSel";
		if (got.srcSel != exp.srcSel) return "srcSel";
		if (got.useImm != exp.useImm) return "useImm";
		if (got.immediate != exp.immediate) return "immediate";
		if (got.wbSel != exp.wbSel) return "wbSel";
		if (got.writeEn1 != exp.writeEn1) return "writeEn1";
		if (got.writeEn2 != exp.writeEn2) return "writeEn2";
		if (got.flagWrite != exp.flagWrite) return "flagWrite";
		if (got.memRead != exp.memRead) return "memRead";
		if (got.memWrite != exp.memWrite) return "memWrite";
		if (got.memAddrFromReg != exp.memAddrFromReg) return "memAddrFromReg";
		if (got.jump != exp.jump) return "jump";
		if (got.target != exp.target) return "target";
		if (got.pcAdvance != exp.pcAdvance) return "pcAdvance";
		return "unknown";
	endfunction

	task automatic reportMismatch(input decodePkg::ctrlWord_t got, input decodePkg::ctrlWord_t exp);
		failRun($sformatf("MISMATCH at %0t: field %s, got %h, expected %h",
			$time, firstBadField(got, exp), got, exp));
	endtask

	//////////////////////////////
	// Scoreboard
	//////////////////////////////

	always @(posedge clk) begin
		afterReset <= !rstN;
		if (!rstN) begin
			scoreQ.delete();
		end else begin
			if (outValid && outReady && scoreQ.size() > 0) begin
				void'(scoreQ.pop_front());
			end
			if (inValid && inReady) begin
				scoreQ.push_back(expectCtrl(inData.instr, inData.flags));
			end
		end
		headValid <= (scoreQ.size() > 0);
		headExpect <= (scoreQ.size() > 0) ? scoreQ[0] : '0;
	end

	resetQuiet: assert property (@(posedge clk) afterReset |-> !outValid)
		else failRun($sformatf("Error at %0t: outValid was high in or right after reset", $time));

	readyAfterReset: assert property (@(posedge clk) afterReset && rstN |-> inReady)
		else failRun($sformatf("Error at %0t: inReady was low right after reset", $time));

	noExtraOutput: assert property (@(posedge clk) disable iff (!rstN)
		outValid && outReady |-> headValid)
		else failRun($sformatf("Error at %0t: an output came out with no input behind it", $time));

	outputMatch: assert property (@(posedge clk) disable iff (!rstN)
		outValid && outReady && headValid |-> outData == headExpect)
		else reportMismatch($sampled(outData), $sampled(headExpect));

	stallHold: assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outData))
		else failRun($sformatf("Error at %0t: outData changed while stalled", $time));

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic addItem(input decodePkg::instr_t instr, input decodePkg::flags_t flags);
		decodePkg::decodeIn_t item;
		item.instr = instr;
		item.flags = flags;
		stimQ.push_back(item);
	endtask

	task automatic buildDirected();
		decodePkg::regIdx_t dests[3];
		for (int op = 0; op < 16; op++) begin
			dests = '{4'(op), decodePkg::bankTwoLow, decodePkg::bankTwoHigh};
			foreach (dests[i]) begin
				addItem({2'b00, 4'h0, dests[i], 4'(op), 4'($urandom)}, 3'($urandom));
				if (op >= 2) begin
					addItem({2'b00, 4'(op), dests[i], 8'($urandom)}, 3'($urandom));
				end
				// Opcodes 2 and 3 here are unused memory moves
				if (op < 4) begin
					addItem({2'b00, 4'h1, dests[i], 4'(op), 4'($urandom)}, 3'($urandom));
				end
			end
		end
		// Seven jump codes against all eight flag values
		for (int code = 8; code < 15; code++) begin
			for (int f = 0; f < 8; f++) begin
				addItem({5'(code), 13'($urandom)}, 3'(f));
			end
		end
		for (int code = 15; code < 24; code++) begin
			addItem({5'(code), 13'($urandom)}, 3'($urandom));
		end
		for (int i = 0; i < 8; i++) begin
			addItem({2'b11, 16'($urandom)}, 3'($urandom));
		end
	endtask

	// Offers items back to back, optionally with a random outReady
	task automatic driveItems(input int first, input int last, input bit stall);
		int idx;
		idx = first;
		while (idx < last) begin
			@(posedge clk);
			#2;
			outReady = stall ? 1'($urandom) : 1'b1;
			inValid = 1'b1;
			inData = stimQ[idx];
			#1;
			if (inReady) begin
				idx++;
			end
		end
		@(posedge clk);
		#2;
		inValid = 1'b0;
	endtask

	initial begin
		int seedDummy;
		int directedCount;
		seedDummy = $urandom(96513);
		rstN = 1'b0;
		inValid = 1'b0;
		inData = '0;
		outReady = 1'b1;
		buildDirected();
		directedCount = stimQ.size();
		for (int i = 0; i < 300; i++) begin
			addItem(18'($urandom), 3'($urandom));
		end
		itemTotal = stimQ.size();
		repeat (8) @(posedge clk);
		#2;
		rstN = 1'b1;
		driveItems(0, directedCount, 1'b0);
		driveItems(directedCount, itemTotal, 1'b1);
		outReady = 1'b1;
		// Last item reaches the output two edges after it was taken
		repeat (2) @(posedge clk);
		#2;
		while (outValid) begin
			@(posedge clk);
			#2;
		end
		if (scoreQ.size() == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			failRun($sformatf("Error: %0d expected outputs never appeared", scoreQ.size()));
		end
	end

	// Watchdog
	initial begin
		wait (itemTotal > 0);
		repeat (itemTotal * 8 + 100) @(posedge clk);
		failRun($sformatf("Timeout: run did not finish within %0d clock cycles",
			itemTotal * 8 + 100));
	end

endmodule

// File: verilog.f
+incdir+verification
src/decodePkg.sv
src/instrClassify.sv
src/fieldDecode.sv
src/branchResolve.sv
src/controlDecoder.sv
verification/decoderTb.sv
